/* Bender.yml */
package:
  name: arty_io

sources:
  - files:
      - source/csr_pkg.sv
      - source/csr_decode.sv
      - source/csr_reg.sv
      - source/csr_readback.sv
      - source/tx_fifo.sv
      - source/uart_tx.sv
      - source/arty_io_top.sv
  - target: test
    files:
      - verif/arty_io_assertions.sv
      - verif/tb_arty_io.sv

/* source/arty_io_top.sv */
// Arty board I/O top
`timescale 1ns/1ps
`default_nettype none

module arty_io_top
  import csr_pkg::*;
#(
  parameter int ClksPerBit = 8,
  parameter int FifoDepth  = 4
) (
  input  logic                clk,
  input  logic                rst_n,
  input  csr_req_t            req,
  output csr_rsp_t            rsp,
  input  logic [BtnWidth-1:0] btn,
  output logic [LedWidth-1:0] led,
  output logic                tx
);

  word        reg_values [NumRegs];
  csr_wr_t    reg_wr [NumRegs];
  logic       csr_hit;
  logic       fifo_push;
  logic [7:0] fifo_byte;
  logic [7:0] fifo_data;
  logic       fifo_have_next;
  word        fifo_status;
  logic       uart_next;

  csr_decode i_decode (
    .req        (req),
    .reg_values (reg_values),
    .wr         (reg_wr),
    .fifo_push  (fifo_push),
    .fifo_byte  (fifo_byte),
    .hit        (csr_hit)
  );

  // led and scratch registers
  for (genvar i = 0; i < NumRegs; i++) begin : g_reg
    csr_reg #(
      .ResetValue (RegReset[i])
    ) i_reg (
      .clk   (clk),
      .rst_n (rst_n),
      .wr    (reg_wr[i]),
      .value (reg_values[i])
    );
  end

  assign led = reg_values[LedIdx][LedWidth-1:0];

  csr_readback i_readback (
    .clk         (clk),
    .rst_n       (rst_n),
    .req         (req),
    .hit         (csr_hit),
    .reg_values  (reg_values),
    .btn         (btn),
    .fifo_status (fifo_status),
    .rsp         (rsp)
  );

  tx_fifo #(
    .FifoDepth (FifoDepth)
  ) i_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (fifo_push),
    .push_byte (fifo_byte),
    .next      (uart_next),
    .data      (fifo_data),
    .have_next (fifo_have_next),
    .status    (fifo_status)
  );

  uart_tx #(
    .ClksPerBit (ClksPerBit)
  ) i_uart (
    .clk       (clk),
    .rst_n     (rst_n),
    .have_next (fifo_have_next),
    .data      (fifo_data),
    .next      (uart_next),
    .tx        (tx)
  );

endmodule

`default_nettype wire

/* source/csr_decode.sv */
// CSR write decoder
`timescale 1ns/1ps
`default_nettype none

module csr_decode
  import csr_pkg::*;
(
  input  csr_req_t   req,
  input  word        reg_values [NumRegs],
  output csr_wr_t    wr [NumRegs],
  output logic       fifo_push,
  output logic [7:0] fifo_byte,
  output logic       hit
);

  word  src;
  logic do_write;

  // new register value for a given op
  function automatic word apply_op(csr_op_t op, word old_value, word s);
    word res;
    case (op)
      CSR_RW:  res = s;
      CSR_RS:  res = old_value | s;
      CSR_RC:  res = old_value & ~s;
      default: res = old_value;
    endcase
    return res;
  endfunction

  // immediate forms use the zero-extended zimm field
  assign src = req.use_imm ? word'(req.rs1_zimm) : req.rs1_data;

  // set/clear with a zero source is a pure read
  always_comb begin
    case (req.op)
      CSR_RW:         do_write = req.valid;
      CSR_RS, CSR_RC: do_write = req.valid && (src != '0);
      default:        do_write = 1'b0;
    endcase
  end

  always_comb begin
    for (int i = 0; i < NumRegs; i++) begin
      wr[i].en   = do_write && (req.addr == RegAddr[i]);
      wr[i].data = apply_op(req.op, reg_values[i], src);
    end
  end

  // tx data register pushes whatever the op
  assign fifo_push = do_write && (req.addr == UartTxAddr);
  assign fifo_byte = src[7:0];

  always_comb begin
    case (req.addr)
      LedAddr,
      BtnAddr,
      Scratch0Addr,
      Scratch1Addr,
      UartTxAddr,
      UartStatAddr: hit = 1'b1;
      default:      hit = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* source/csr_pkg.sv */
// CSR map and types
`default_nettype none

package csr_pkg;

  typedef logic [31:0] word;
  typedef logic [11:0] CsrAddrT;

  // low two bits of funct3, as in csrrw/csrrs/csrrc
  typedef enum logic [1:0] {
    CSR_RW = 2'b01,
    CSR_RS = 2'b10,
    CSR_RC = 2'b11
  } csr_op_t;

  typedef struct packed {
    logic        valid;
    csr_op_t     op;
    logic        use_imm;
    CsrAddrT     addr;
    logic [4:0]  rs1_zimm;
    word         rs1_data;
  } csr_req_t;

  typedef struct packed {
    logic valid;
    logic err;
    word  data;
  } csr_rsp_t;

  // write command for one software register
  typedef struct packed {
    logic en;
    word  data;
  } csr_wr_t;

  // board i/o block in the custom read/write range
  localparam CsrAddrT LedAddr      = 12'h7C0;
  localparam CsrAddrT BtnAddr      = 12'h7C1;
  localparam CsrAddrT Scratch0Addr = 12'h7C2;
  localparam CsrAddrT Scratch1Addr = 12'h7C3;
  localparam CsrAddrT UartTxAddr   = 12'h7C4;
  localparam CsrAddrT UartStatAddr = 12'h7C5;

  localparam int LedWidth = 4;
  localparam int BtnWidth = 4;

  // software registers, led first
  localparam int NumRegs = 3;
  localparam int LedIdx  = 0;
  localparam CsrAddrT RegAddr [NumRegs] = '{LedAddr, Scratch0Addr, Scratch1Addr};
  localparam word RegReset [NumRegs] = '{32'h0000_0000, 32'h0000_00A5, 32'h0000_0000};

endpackage

`default_nettype wire

/* source/csr_readback.sv */
// CSR read response
`timescale 1ns/1ps
`default_nettype none

module csr_readback
  import csr_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  csr_req_t            req,
  input  logic                hit,
  input  word                 reg_values [NumRegs],
  input  logic [BtnWidth-1:0] btn,
  input  word                 fifo_status,
  output csr_rsp_t            rsp
);

  logic [BtnWidth-1:0] btn_meta;
  logic [BtnWidth-1:0] btn_sync;
  word                 old_value;
  logic                rsp_valid;
  logic                rsp_err;
  word                 rsp_data;

  // two-flop synchronizer for the buttons
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      btn_meta <= '0;
      btn_sync <= '0;
    end else begin
      btn_meta <= btn;
      btn_sync <= btn_meta;
    end
  end

  // value before the access, tx data reads as zero
  always_comb begin
    old_value = '0;
    for (int i = 0; i < NumRegs; i++) begin
      if (req.addr == RegAddr[i]) old_value = reg_values[i];
    end
    if (req.addr == BtnAddr) old_value = word'(btn_sync);
    if (req.addr == UartStatAddr) old_value = fifo_status;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) rsp_valid <= 1'b0;
    else rsp_valid <= req.valid;
  end

  always_ff @(posedge clk) begin
    if (req.valid) begin
      rsp_err  <= !hit;
      rsp_data <= hit ? old_value : '0;
    end
  end

  assign rsp = '{valid: rsp_valid, err: rsp_err, data: rsp_data};

endmodule

`default_nettype wire

/* source/csr_reg.sv */
// software CSR
`timescale 1ns/1ps
`default_nettype none

module csr_reg
  import csr_pkg::*;
#(
  parameter word ResetValue = '0
) (
  input  logic    clk,
  input  logic    rst_n,
  input  csr_wr_t wr,
  output word     value
);

  word value_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      value_q <= ResetValue;
    end else if (wr.en) begin
      value_q <= wr.data;
    end
  end

  assign value = value_q;

endmodule

`default_nettype wire

/* source/tx_fifo.sv */
// UART transmit FIFO
`timescale 1ns/1ps
`default_nettype none

module tx_fifo
  import csr_pkg::*;
#(
  parameter int FifoDepth = 4
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       push,
  input  logic [7:0] push_byte,
  input  logic       next,
  output logic [7:0] data,
  output logic       have_next,
  output word        status
);

  localparam int PtrWidth   = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int CountWidth = $clog2(FifoDepth + 1);

  logic [7:0]            mem [FifoDepth];
  logic [PtrWidth-1:0]   wr_ptr;
  logic [PtrWidth-1:0]   rd_ptr;
  logic [CountWidth-1:0] count;
  logic                  overflow;
  logic                  empty;
  logic                  full;
  logic                  push_ok;
  logic                  pop;

  // wrap explicitly so any depth works
  function automatic logic [PtrWidth-1:0] ptr_inc(logic [PtrWidth-1:0] ptr);
    return (ptr == PtrWidth'(FifoDepth - 1)) ? '0 : ptr + PtrWidth'(1);
  endfunction

  assign empty   = (count == '0);
  assign full    = (count == CountWidth'(FifoDepth));
  assign push_ok = push && !full;
  assign pop     = next && !empty;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (push_ok) wr_ptr <= ptr_inc(wr_ptr);
      if (pop) rd_ptr <= ptr_inc(rd_ptr);
      if (push_ok && !pop) count <= count + CountWidth'(1);
      else if (pop && !push_ok) count <= count - CountWidth'(1);
      // sticky until reset
      if (push && full) overflow <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push_ok) mem[wr_ptr] <= push_byte;
  end

  assign data      = mem[rd_ptr];
  assign have_next = !empty;

  always_comb begin
    status                  = '0;
    status[0]               = empty;
    status[1]               = full;
    status[2]               = overflow;
    status[8+:CountWidth]   = count;
  end

endmodule

`default_nettype wire

/* source/uart_tx.sv */
// 8N1 UART transmitter
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
  parameter int ClksPerBit = 8
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       have_next,
  input  logic [7:0] data,
  output logic       next,
  output logic       tx
);

  localparam int BaudWidth = (ClksPerBit > 1) ? $clog2(ClksPerBit) : 1;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SHIFT,
    ST_STOP
  } state_t;

  state_t               state;
  logic [BaudWidth-1:0] baud_cnt;
  logic [3:0]           bit_cnt;
  logic [7:0]           shift_q;
  logic                 tx_q;
  logic                 bit_done;

  assign bit_done = (baud_cnt == BaudWidth'(ClksPerBit - 1));

  // load strobe back to the FIFO
  assign next = (state == ST_IDLE) && have_next;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= ST_IDLE;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      tx_q     <= 1'b1;
    end else begin
      case (state)
        ST_IDLE: begin
          if (have_next) begin
            // start bit goes out right away
            state    <= ST_SHIFT;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            tx_q     <= 1'b0;
          end
        end
        ST_SHIFT: begin
          baud_cnt <= bit_done ? '0 : baud_cnt + BaudWidth'(1);
          if (bit_done) begin
            if (bit_cnt == 4'd8) begin
              state <= ST_STOP;
              tx_q  <= 1'b1;
            end else begin
              tx_q    <= shift_q[0];
              bit_cnt <= bit_cnt + 4'd1;
            end
          end
        end
        ST_STOP: begin
          baud_cnt <= bit_done ? '0 : baud_cnt + BaudWidth'(1);
          if (bit_done) state <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // data shifter, lsb first
  always_ff @(posedge clk) begin
    if (next) shift_q <= data;
    else if (state == ST_SHIFT && bit_done && bit_cnt != 4'd8) shift_q <= shift_q >> 1;
  end

  assign tx = tx_q;

endmodule

`default_nettype wire

/* verif/arty_io_assertions.sv */
// CSR and UART assertions
`timescale 1ns/1ps
`default_nettype none

module arty_io_assertions
  import csr_pkg::*;
(
  input logic     clk,
  input logic     rst_n,
  input csr_req_t req,
  input csr_rsp_t rsp,
  input logic     hit,
  input logic     fifo_empty,
  input logic     uart_idle,
  input logic     tx
);

  int unsigned fail_count = 0;

  // exactly one response per request, one cycle later
  rsp_follows_req: assert property (@(posedge clk) disable iff (!rst_n)
    rsp.valid == $past(req.valid))
    else begin
      fail_count++;
      $error("response strobe does not follow the request by one cycle");
    end

  tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
    (fifo_empty && uart_idle) |-> tx)
    else begin
      fail_count++;
      $error("tx low while the FIFO is empty and the UART is idle");
    end

  no_err_on_hit: assert property (@(posedge clk) disable iff (!rst_n)
    (req.valid && hit) |=> !rsp.err)
    else begin
      fail_count++;
      $error("err set in a response to a mapped address");
    end

endmodule

bind arty_io_top arty_io_assertions i_assertions (
  .clk        (clk),
  .rst_n      (rst_n),
  .req        (req),
  .rsp        (rsp),
  .hit        (csr_hit),
  .fifo_empty (fifo_status[0]),
  .uart_idle  (i_uart.state == 2'd0),
  .tx         (tx)
);

`default_nettype wire

/* verif/tb_arty_io.sv */
// Arty I/O testbench
`timescale 1ns/1ps
`default_nettype none

module tb_arty_io
  import csr_pkg::*;
();

  localparam int ClksPerBit = 8;
  localparam int FifoDepth  = 4;

  logic                clk;
  logic                rst_n;
  csr_req_t            req;
  csr_rsp_t            rsp;
  logic [BtnWidth-1:0] btn;
  logic [LedWidth-1:0] led;
  logic                tx;
  int                  seed = 82250;

  // expected register contents in loop order
  CsrAddrT reg_addr [NumRegs] = '{LedAddr, Scratch0Addr, Scratch1Addr};
  word     model [NumRegs] = '{32'h0000_0000, 32'h0000_00A5, 32'h0000_0000};

  arty_io_top #(
    .ClksPerBit (ClksPerBit),
    .FifoDepth  (FifoDepth)
  ) DUT (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .rsp   (rsp),
    .btn   (btn),
    .led   (led),
    .tx    (tx)
  );

  always #2 clk = ~clk;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1, "stopping at the first error");
  endtask

  function automatic csr_rsp_t expected_rsp(input logic err, input word data);
    csr_rsp_t r;
    r.valid = 1'b1;
    r.err   = err;
    r.data  = data;
    return r;
  endfunction

  // csrrw/csrrs/csrrc result
  function automatic word op_result(input csr_op_t op, input word old_value, input word src);
    if (op == CSR_RW) return src;
    if (op == CSR_RS) return old_value | src;
    return old_value & ~src;
  endfunction

  task automatic check_rsp(input csr_rsp_t got, input csr_rsp_t exp, input string what);
    string msg;
    if (got !== exp) begin
      msg = $sformatf("Error at %0t ns: %s got v=%b err=%b data=%h", $time, what,
                      got.valid, got.err, got.data);
      abort_run($sformatf("%s, expected v=%b err=%b data=%h", msg,
                          exp.valid, exp.err, exp.data));
    end
  endtask

  task automatic check_led(input logic [LedWidth-1:0] got, input logic [LedWidth-1:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("Error at %0t ns: led got %b, expected %b", $time, got, exp));
    end
  endtask

  task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("Error at %0t ns: %s got %h, expected %h", $time, what, got, exp));
    end
  endtask

  // one request strobe with the response sampled mid-cycle
  task automatic csr_access(input csr_op_t op, input logic use_imm, input CsrAddrT addr,
                            input word data, output csr_rsp_t got);
    csr_req_t r;
    int       waited;
    r.valid    = 1'b1;
    r.op       = op;
    r.use_imm  = use_imm;
    r.addr     = addr;
    r.rs1_zimm = data[4:0];
    r.rs1_data = data;
    @(posedge clk);
    req <= r;
    @(posedge clk);
    req <= '0;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
      if (waited > 10) abort_run("timeout waiting for the CSR response strobe");
    end while (rsp.valid !== 1'b1);
    got = rsp;
  endtask

  // set with a zero source is a plain read
  task automatic csr_read(input CsrAddrT addr, output csr_rsp_t got);
    csr_access(CSR_RS, 1'b0, addr, 32'h0, got);
  endtask

  task automatic receive_byte(output logic [7:0] b);
    int waited;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
      if (waited > 40 * ClksPerBit) abort_run("timeout waiting for a UART start bit");
    end while (tx !== 1'b0);
    repeat (ClksPerBit / 2) @(negedge clk);
    if (tx !== 1'b0) abort_run("UART start bit ended too early");
    for (int n = 0; n < 8; n++) begin
      repeat (ClksPerBit) @(negedge clk);
      b[n] = tx;
    end
    repeat (ClksPerBit) @(negedge clk);
    if (tx !== 1'b1) abort_run("UART stop bit missing");
  endtask

  task automatic read_reset_values();
    csr_rsp_t got;
    for (int i = 0; i < NumRegs; i++) begin
      csr_read(reg_addr[i], got);
      check_rsp(got, expected_rsp(1'b0, model[i]), "reset value");
    end
    csr_read(BtnAddr, got);
    check_rsp(got, expected_rsp(1'b0, 32'h0), "button after reset");
    csr_read(UartStatAddr, got);
    check_rsp(got, expected_rsp(1'b0, 32'h1), "status after reset");
    csr_read(UartTxAddr, got);
    check_rsp(got, expected_rsp(1'b0, 32'h0), "tx data after reset");
    check_led(led, '0);
  endtask

  task automatic run_register_ops();
    csr_op_t  ops [3] = '{CSR_RW, CSR_RS, CSR_RC};
    csr_rsp_t got;
    word      data;
    for (int i = 0; i < NumRegs; i++) begin
      foreach (ops[k]) begin
        data = $random(seed);
        csr_access(ops[k], 1'b0, reg_addr[i], data, got);
        check_rsp(got, expected_rsp(1'b0, model[i]), "old value");
        model[i] = op_result(ops[k], model[i], data);
        csr_read(reg_addr[i], got);
        check_rsp(got, expected_rsp(1'b0, model[i]), "new value");
        check_led(led, model[0][LedWidth-1:0]);
      end
    end
  endtask

  task automatic write_imm_and_readonly();
    csr_rsp_t got;
    word      data;
    for (int i = 0; i < NumRegs; i++) begin
      data = $random(seed);
      csr_access(CSR_RW, 1'b1, reg_addr[i], data, got);
      check_rsp(got, expected_rsp(1'b0, model[i]), "imm write old value");
      model[i] = word'(data[4:0]);
      // zero zimm so rs1_data must be ignored
      csr_access(CSR_RS, 1'b1, reg_addr[i], data & 32'hFFFF_FFE0, got);
      check_rsp(got, expected_rsp(1'b0, model[i]), "imm set with zero");
      csr_access(CSR_RC, 1'b0, reg_addr[i], 32'h0, got);
      check_rsp(got, expected_rsp(1'b0, model[i]), "clear with zero");
      csr_read(reg_addr[i], got);
      check_rsp(got, expected_rsp(1'b0, model[i]), "value after zero source");
      check_led(led, model[0][LedWidth-1:0]);
    end
    csr_access(CSR_RW, 1'b0, BtnAddr, $random(seed), got);
    check_rsp(got, expected_rsp(1'b0, 32'h0), "button write old value");
    csr_read(BtnAddr, got);
    check_rsp(got, expected_rsp(1'b0, 32'h0), "button after write");
    csr_access(CSR_RW, 1'b0, UartStatAddr, $random(seed), got);
    check_rsp(got, expected_rsp(1'b0, 32'h1), "status write old value");
    csr_read(UartStatAddr, got);
    check_rsp(got, expected_rsp(1'b0, 32'h1), "status after write");
  endtask

  task automatic poll_buttons();
    logic [BtnWidth-1:0] pattern;
    csr_rsp_t            got;
    int                  tries;
    pattern = BtnWidth'($random(seed)) | BtnWidth'(1);
    @(posedge clk);
    btn <= pattern;
    tries = 0;
    do begin
      tries++;
      if (tries > 10) abort_run("button value never reached the button CSR");
      csr_read(BtnAddr, got);
    end while (got.data !== word'(pattern));
  endtask

  task automatic send_uart_frames();
    word        sent [3];
    logic [7:0] seen;
    csr_rsp_t   got;
    foreach (sent[k]) sent[k] = $random(seed);
    // monitor runs alongside the writes
    fork
      begin
        foreach (sent[k]) begin
          csr_access(CSR_RW, 1'b0, UartTxAddr, sent[k], got);
          check_rsp(got, expected_rsp(1'b0, 32'h0), "tx data write");
        end
      end
      begin
        for (int k = 0; k < 3; k++) begin
          receive_byte(seen);
          check_byte(seen, sent[k][7:0], "uart frame");
        end
      end
    join
    csr_read(UartStatAddr, got);
    check_rsp(got, expected_rsp(1'b0, 32'h1), "status after frames");
  endtask

  task automatic overflow_and_unmapped();
    csr_rsp_t got;
    for (int k = 0; k < FifoDepth + 2; k++) begin
      csr_access(CSR_RW, 1'b0, UartTxAddr, $random(seed), got);
    end
    // the UART takes one byte and the rest fill the FIFO
    csr_read(UartStatAddr, got);
    check_rsp(got, expected_rsp(1'b0, (FifoDepth << 8) | 32'h6), "status after overflow");
    csr_read(12'h123, got);
    check_rsp(got, expected_rsp(1'b1, 32'h0), "unmapped read");
  endtask

  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
    req   = '0;
    btn   = '0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    read_reset_values();
    run_register_ops();
    write_imm_and_readonly();
    poll_buttons();
    send_uart_frames();
    overflow_and_unmapped();
    @(posedge clk);
    if (DUT.i_assertions.fail_count == 0) begin
      $display("sim passed");
      $finish;
    end else begin
      abort_run("an assertion failed during the run");
    end
  end

endmodule

`default_nettype wire

/* verilog.f */
source/csr_pkg.sv
source/csr_decode.sv
source/csr_reg.sv
source/csr_readback.sv
source/tx_fifo.sv
source/uart_tx.sv
source/arty_io_top.sv
verif/arty_io_assertions.sv
verif/tb_arty_io.sv
